/* rtl/core_pkg.sv */
// Core front end shared definitions

package core_pkg;

  // ============================================================
  // Datapath and instruction field positions
  // ============================================================
  localparam int XLEN = 32;

  localparam int OPC_LSB = 2;   // Major opcode, low two bits are the 11 marker
  localparam int OPC_MSB = 6;
  localparam int RD_LSB  = 7;
  localparam int RD_MSB  = 11;
  localparam int F3_LSB  = 12;
  localparam int F3_MSB  = 14;
  localparam int RS1_LSB = 15;
  localparam int RS1_MSB = 19;
  localparam int RS2_LSB = 20;
  localparam int RS2_MSB = 24;
  localparam int F7_LSB  = 25;
  localparam int F7_MSB  = 31;

  localparam logic [6:0] FUNCT7_ALT = 7'h20;  // SUB / SRA select

  // ============================================================
  // Opcodes and unit select
  // ============================================================
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    OPIMM  = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    OPV    = 5'b10101,  // Vector extension
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011,
    SYSTEM = 5'b11100
  } opcode_e;

  // One-hot, zero means no unit
  typedef enum logic [2:0] {
    EXEC_NONE = 3'b000,
    EXEC_INT  = 3'b001,
    EXEC_LSU  = 3'b010,
    EXEC_VEC  = 3'b100
  } exec_unit_e;

  // ============================================================
  // Micro-ops
  // ============================================================
  typedef enum logic [3:0] {
    UOP_ADD    = 4'd0,  UOP_SUB  = 4'd1,  UOP_OR   = 4'd2,  UOP_AND  = 4'd3,
    UOP_XOR    = 4'd4,  UOP_BEQ  = 4'd5,  UOP_BNE  = 4'd6,  UOP_BLT  = 4'd7,
    UOP_BGE    = 4'd8,  UOP_PASS_B = 4'd9, UOP_SLT = 4'd10, UOP_SLTU = 4'd11,
    UOP_BLTU   = 4'd12, UOP_SRA  = 4'd13, UOP_SRL  = 4'd14, UOP_SLL  = 4'd15
  } int_uop_e;

  // Shares the ADD code, only meaningful on the BRANCH opcode
  localparam logic [3:0] UOP_BGEU = 4'b0000;

  typedef enum logic [3:0] {
    LSU_LB  = 4'd1,
    LSU_LH  = 4'd2,
    LSU_LW  = 4'd3,
    LSU_LBU = 4'd5,
    LSU_LHU = 4'd6,
    LSU_SB  = 4'd9,
    LSU_SH  = 4'd10,
    LSU_SW  = 4'd12
  } lsu_uop_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

endpackage

/* rtl/decode_if.sv */
// Decoded packet bus
`timescale 1ns/1ps

interface decode_if;
  import core_pkg::*;

  logic             valid;    // Packet held in the stage
  logic             ready;    // Selected port accepts
  exec_unit_e       unit;
  logic [3:0]       uop;
  logic             illegal;  // Steers to the exception port
  logic             pc_sel;   // Operand A from PC
  logic             imm_sel;  // Operand B from immediate
  logic [XLEN-1:0]  imm;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [XLEN-1:0]  pc;
  logic [XLEN-1:0]  instr;    // Raw word for exception report

  // Decode stage side
  modport stage (
    output valid, unit, uop, illegal, pc_sel, imm_sel, imm,
    output rs1, rs2, rd, pc, instr,
    input  ready
  );

  // Dispatch side
  modport disp (
    input  valid, unit, uop, illegal, pc_sel, imm_sel, imm,
    input  rs1, rs2, rd, pc, instr,
    output ready
  );

endinterface

/* rtl/decode_unit.sv */
// Opcode and funct decoder
`timescale 1ns/1ps

module decode_unit (
  input  logic [core_pkg::XLEN-1:0] instr,
  output core_pkg::exec_unit_e      unit,
  output logic [3:0]                uop,
  output logic                      pc_sel,
  output logic                      imm_sel,
  output core_pkg::imm_fmt_e        imm_fmt,
  output logic                      illegal
);
  import core_pkg::*;

  opcode_e    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       f7_zero;
  logic       f7_alt;

  assign opc     = opcode_e'(instr[OPC_MSB:OPC_LSB]);
  assign f3      = instr[F3_MSB:F3_LSB];
  assign f7      = instr[F7_MSB:F7_LSB];
  assign f7_zero = (f7 == 7'h00);
  assign f7_alt  = (f7 == FUNCT7_ALT);

  // ============================================================
  // Unit, micro-op, operand selects, immediate format
  // ============================================================
  always_comb begin
    unit    = EXEC_NONE;  // Unknown opcode stays here
    uop     = UOP_ADD;
    pc_sel  = 1'b0;
    imm_sel = 1'b0;
    imm_fmt = IMM_NONE;
    illegal = 1'b0;
    case (opc)
      OP: begin
        unit = EXEC_INT;
        // Only ADD/SUB and SRL/SRA have an alternate encoding
        if (!(f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101))))
          illegal = 1'b1;
        case (f3)
          3'b000:  uop = f7_alt ? UOP_SUB : UOP_ADD;
          3'b001:  uop = UOP_SLL;
          3'b010:  uop = UOP_SLT;
          3'b011:  uop = UOP_SLTU;
          3'b100:  uop = UOP_XOR;
          3'b101:  uop = f7_alt ? UOP_SRA : UOP_SRL;
          3'b110:  uop = UOP_OR;
          default: uop = UOP_AND;
        endcase
      end
      OPIMM: begin
        unit    = EXEC_INT;
        imm_sel = 1'b1;
        imm_fmt = IMM_I;
        case (f3)
          3'b000:  uop = UOP_ADD;
          3'b001: begin
            uop     = UOP_SLL;
            illegal = !f7_zero;  // SLLI has no alternate
          end
          3'b010:  uop = UOP_SLT;
          3'b011:  uop = UOP_SLTU;
          3'b100:  uop = UOP_XOR;
          3'b101: begin
            uop     = f7_alt ? UOP_SRA : UOP_SRL;  // Arithmetic bit from instr[30]
            illegal = !(f7_zero || f7_alt);
          end
          3'b110:  uop = UOP_OR;
          default: uop = UOP_AND;
        endcase
      end
      LOAD: begin
        unit    = EXEC_LSU;
        imm_sel = 1'b1;
        imm_fmt = IMM_I;
        case (f3)
          3'b000:  uop = LSU_LB;
          3'b001:  uop = LSU_LH;
          3'b010:  uop = LSU_LW;
          3'b100:  uop = LSU_LBU;
          3'b101:  uop = LSU_LHU;
          default: illegal = 1'b1;  // 3, 6, 7
        endcase
      end
      STORE: begin
        unit    = EXEC_LSU;
        imm_sel = 1'b1;
        imm_fmt = IMM_S;
        case (f3)
          3'b000:  uop = LSU_SB;
          3'b001:  uop = LSU_SH;
          3'b010:  uop = LSU_SW;
          default: illegal = 1'b1;
        endcase
      end
      BRANCH: begin
        unit    = EXEC_INT;
        pc_sel  = 1'b1;
        imm_fmt = IMM_B;  // imm_sel stays low, operand B is rs2
        case (f3)
          3'b000:  uop = UOP_BEQ;
          3'b001:  uop = UOP_BNE;
          3'b100:  uop = UOP_BLT;
          3'b101:  uop = UOP_BGE;
          3'b110:  uop = UOP_BLTU;
          3'b111:  uop = UOP_BGEU;
          default: illegal = 1'b1;  // 2 and 3 unused
        endcase
      end
      LUI: begin
        unit    = EXEC_INT;
        uop     = UOP_PASS_B;  // Immediate straight through
        imm_sel = 1'b1;
        imm_fmt = IMM_U;
      end
      AUIPC: begin
        unit    = EXEC_INT;
        pc_sel  = 1'b1;
        imm_sel = 1'b1;
        imm_fmt = IMM_U;
      end
      JAL: begin
        unit    = EXEC_INT;
        pc_sel  = 1'b1;
        imm_sel = 1'b1;
        imm_fmt = IMM_J;
      end
      JALR: begin
        unit    = EXEC_INT;
        pc_sel  = 1'b1;
        imm_sel = 1'b1;
        imm_fmt = IMM_I;
      end
      SYSTEM: begin
        unit    = EXEC_INT;  // No CSR semantics, plain ADD
        imm_fmt = IMM_I;
      end
      OPV: begin
        unit = EXEC_VEC;
        uop  = {1'b0, f3};
      end
      default: illegal = 1'b1;
    endcase
    if (instr[1:0] != 2'b11)
      illegal = 1'b1;  // Compressed or reserved
  end

endmodule

/* rtl/imm_gen.sv */
// Immediate extraction
`timescale 1ns/1ps

module imm_gen (
  input  logic [core_pkg::XLEN-1:0] instr,
  input  core_pkg::imm_fmt_e        fmt,
  output logic [core_pkg::XLEN-1:0] imm
);
  import core_pkg::*;

  logic sgn;

  assign sgn = instr[XLEN-1];  // Sign bit is always instr[31]

  // ============================================================
  // Format mux
  // ============================================================
  always_comb begin
    case (fmt)
      IMM_I: begin
        imm = {{20{sgn}}, instr[31:20]};
      end
      IMM_S: begin
        // Split around rd field
        imm = {{20{sgn}}, instr[31:25], instr[11:7]};
      end
      IMM_B: begin
        // Bit 11 lives in instr[7], LSB implied zero
        imm = {{19{sgn}}, sgn, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      IMM_U: begin
        imm = {instr[31:12], 12'h000};  // Upper 20 bits
      end
      IMM_J: begin
        // Scrambled jump offset
        imm = {{11{sgn}}, sgn, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0;  // R-type and vector
      end
    endcase
  end

endmodule

/* rtl/decode_stage.sv */
// Registered decode stage
`timescale 1ns/1ps

module decode_stage (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [core_pkg::XLEN-1:0] in_instr,
  input  logic [core_pkg::XLEN-1:0] in_pc,
  decode_if.stage                   dec
);
  import core_pkg::*;

  exec_unit_e      unit_d;
  logic [3:0]      uop_d;
  logic            pc_sel_d;
  logic            imm_sel_d;
  imm_fmt_e        fmt_d;
  logic            illegal_d;
  logic [XLEN-1:0] imm_d;
  logic            accept;

  // ============================================================
  // Combinational decode of the incoming word
  // ============================================================
  decode_unit u_decode (
    .instr   (in_instr),
    .unit    (unit_d),
    .uop     (uop_d),
    .pc_sel  (pc_sel_d),
    .imm_sel (imm_sel_d),
    .imm_fmt (fmt_d),
    .illegal (illegal_d)
  );

  imm_gen u_imm (
    .instr (in_instr),
    .fmt   (fmt_d),
    .imm   (imm_d)
  );

  // Empty, or draining this cycle
  assign in_ready = !dec.valid || dec.ready;
  assign accept   = in_valid && in_ready;

  // ============================================================
  // One-entry output register
  // ============================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec.valid <= 1'b0;
    end else if (accept) begin
      dec.valid <= 1'b1;           // New packet replaces or fills
    end else if (dec.ready) begin
      dec.valid <= 1'b0;           // Consumed, nothing behind it
    end
  end

  // Payload only moves on a handshake, held under back-pressure
  always_ff @(posedge clk) begin
    if (accept) begin
      dec.unit    <= unit_d;
      dec.uop     <= uop_d;
      dec.illegal <= illegal_d;
      dec.pc_sel  <= pc_sel_d;
      dec.imm_sel <= imm_sel_d;
      dec.imm     <= imm_d;
      dec.rs1     <= in_instr[RS1_MSB:RS1_LSB];
      dec.rs2     <= in_instr[RS2_MSB:RS2_LSB];
      dec.rd      <= in_instr[RD_MSB:RD_LSB];
      dec.pc      <= in_pc;
      dec.instr   <= in_instr;
    end
  end

endmodule

/* rtl/dispatch_unit.sv */
// Unit dispatch
`timescale 1ns/1ps

module dispatch_unit (
  decode_if.disp                    dec,
  output logic                      int_valid,
  input  logic                      int_ready,
  output logic                      lsu_valid,
  input  logic                      lsu_ready,
  output logic                      vec_valid,
  input  logic                      vec_ready,
  output logic                      exc_valid,
  input  logic                      exc_ready,
  output logic [core_pkg::XLEN-1:0] exc_instr,
  output logic [core_pkg::XLEN-1:0] exc_pc,
  output logic [3:0]                out_uop,
  output logic [core_pkg::XLEN-1:0] out_imm,
  output logic [core_pkg::XLEN-1:0] out_pc,
  output logic [4:0]                out_rs1,
  output logic [4:0]                out_rs2,
  output logic [4:0]                out_rd,
  output logic                      out_pc_sel,
  output logic                      out_imm_sel
);
  import core_pkg::*;

  // ============================================================
  // Valid steering and ready return
  // ============================================================
  always_comb begin
    int_valid = 1'b0;
    lsu_valid = 1'b0;
    vec_valid = 1'b0;
    exc_valid = 1'b0;
    dec.ready = 1'b0;
    if (dec.illegal) begin
      // Illegal wins over any unit select
      exc_valid = dec.valid;
      dec.ready = exc_ready;
    end else begin
      case (dec.unit)
        EXEC_INT: begin
          int_valid = dec.valid;
          dec.ready = int_ready;
        end
        EXEC_LSU: begin
          lsu_valid = dec.valid;
          dec.ready = lsu_ready;
        end
        EXEC_VEC: begin
          vec_valid = dec.valid;
          dec.ready = vec_ready;
        end
        default: begin
          exc_valid = dec.valid;  // No unit, treat as exception
          dec.ready = exc_ready;
        end
      endcase
    end
  end

  // Shared payload, qualified by the port valids
  assign out_uop     = dec.uop;
  assign out_imm     = dec.imm;
  assign out_pc      = dec.pc;
  assign out_rs1     = dec.rs1;
  assign out_rs2     = dec.rs2;
  assign out_rd      = dec.rd;
  assign out_pc_sel  = dec.pc_sel;
  assign out_imm_sel = dec.imm_sel;
  assign exc_instr   = dec.instr;  // Faulting word
  assign exc_pc      = dec.pc;

endmodule

/* rtl/core_frontend_top.sv */
// Decode and dispatch front end
`timescale 1ns/1ps

module core_frontend_top (
  input  logic                      clk,
  input  logic                      arst_n,
  // Instruction input
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [core_pkg::XLEN-1:0] in_instr,
  input  logic [core_pkg::XLEN-1:0] in_pc,
  // Shared payload
  output logic [3:0]                out_uop,
  output logic [core_pkg::XLEN-1:0] out_imm,
  output logic [core_pkg::XLEN-1:0] out_pc,
  output logic [4:0]                out_rs1,
  output logic [4:0]                out_rs2,
  output logic [4:0]                out_rd,
  output logic                      out_pc_sel,
  output logic                      out_imm_sel,
  // Unit ports
  output logic                      int_valid,
  input  logic                      int_ready,
  output logic                      lsu_valid,
  input  logic                      lsu_ready,
  output logic                      vec_valid,
  input  logic                      vec_ready,
  // Exception port
  output logic                      exc_valid,
  input  logic                      exc_ready,
  output logic [core_pkg::XLEN-1:0] exc_instr,
  output logic [core_pkg::XLEN-1:0] exc_pc
);

  decode_if dec_bus ();

  decode_stage u_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_instr (in_instr),
    .in_pc    (in_pc),
    .dec      (dec_bus.stage)
  );

  dispatch_unit u_disp (
    .dec         (dec_bus.disp),
    .int_valid   (int_valid),
    .int_ready   (int_ready),
    .lsu_valid   (lsu_valid),
    .lsu_ready   (lsu_ready),
    .vec_valid   (vec_valid),
    .vec_ready   (vec_ready),
    .exc_valid   (exc_valid),
    .exc_ready   (exc_ready),
    .exc_instr   (exc_instr),
    .exc_pc      (exc_pc),
    .out_uop     (out_uop),
    .out_imm     (out_imm),
    .out_pc      (out_pc),
    .out_rs1     (out_rs1),
    .out_rs2     (out_rs2),
    .out_rd      (out_rd),
    .out_pc_sel  (out_pc_sel),
    .out_imm_sel (out_imm_sel)
  );

endmodule

/* dv/core_frontend_properties.sv */
// Front end handshake assertions
`timescale 1ns/1ps

module core_frontend_properties (
  input logic        clk,
  input logic        arst_n,
  input logic        in_valid,
  input logic        in_ready,
  input logic        int_valid,
  input logic        int_ready,
  input logic        lsu_valid,
  input logic        lsu_ready,
  input logic        vec_valid,
  input logic        vec_ready,
  input logic        exc_valid,
  input logic        exc_ready,
  input logic [3:0]  out_uop,
  input logic [31:0] out_imm,
  input logic [31:0] out_pc,
  input logic [4:0]  out_rs1,
  input logic [4:0]  out_rs2,
  input logic [4:0]  out_rd,
  input logic        out_pc_sel,
  input logic        out_imm_sel,
  input logic [31:0] exc_instr
);

  logic [3:0]   valids;
  logic [3:0]   readies;
  logic         stalled;
  logic [116:0] payload;

  assign valids  = {exc_valid, vec_valid, lsu_valid, int_valid};
  assign readies = {exc_ready, vec_ready, lsu_ready, int_ready};
  assign stalled = |(valids & ~readies);  // Some port held off
  assign payload = {out_uop, out_imm, out_pc, out_rs1, out_rs2, out_rd,
                    out_pc_sel, out_imm_sel, exc_instr};

  // ============================================================
  // Routing and handshake rules
  // ============================================================
  a_one_valid : assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(valids))
    else $error("More than one output port valid");

  // Held packet keeps its port and payload
  a_hold : assert property (@(posedge clk) disable iff (!arst_n)
    stalled |=> (valids == $past(valids)) && $stable(payload))
    else $error("Stalled packet changed");

  a_ready_after_reset : assert property (@(posedge clk)
    $rose(arst_n) |-> in_ready)
    else $error("in_ready low after reset");

  a_latency : assert property (@(posedge clk) disable iff (!arst_n)
    (in_valid && in_ready) |=> |valids)
    else $error("No output valid one cycle after accept");

endmodule

/* dv/tb_core_frontend.sv */
// Front end directed testbench
`timescale 1ns/1ps

module tb_core_frontend;
  import core_pkg::*;

  localparam int N_DIRECTED      = 80;   // Upper bound on directed sends
  localparam int N_RANDOM        = 250;
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;

  localparam logic [1:0] P_INT = 2'd0;
  localparam logic [1:0] P_LSU = 2'd1;
  localparam logic [1:0] P_VEC = 2'd2;
  localparam logic [1:0] P_EXC = 2'd3;

  typedef struct packed {
    logic [1:0]  port;     // Expected output port
    logic [3:0]  uop;
    logic        pc_sel;
    logic        imm_sel;
    logic [31:0] imm;
  } expect_t;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] in_instr;
  logic [31:0] in_pc;
  logic [3:0]  out_uop;
  logic [31:0] out_imm;
  logic [31:0] out_pc;
  logic [4:0]  out_rs1;
  logic [4:0]  out_rs2;
  logic [4:0]  out_rd;
  logic        out_pc_sel;
  logic        out_imm_sel;
  logic        int_valid;
  logic        int_ready;
  logic        lsu_valid;
  logic        lsu_ready;
  logic        vec_valid;
  logic        vec_ready;
  logic        exc_valid;
  logic        exc_ready;
  logic [31:0] exc_instr;
  logic [31:0] exc_pc;

  logic [31:0] rng = 32'd1;           // Xorshift state
  logic [31:0] pc_next = 32'h0000_1000;
  logic        strict_latency;        // All ports ready, exactly one cycle
  logic        rand_ready;
  int          cycle = 0;
  int          n_accepted = 0;
  logic [31:0] instr_q[$];            // Accepted, not yet retired
  logic [31:0] pc_q[$];
  int          cyc_q[$];

  // Micro-op tables indexed by funct3, zero marks a hole
  logic [3:0] alu_uop [8] = '{4'd0, 4'd15, 4'd10, 4'd11, 4'd4, 4'd14, 4'd2, 4'd3};
  logic [3:0] ld_uop  [8] = '{4'd1, 4'd2, 4'd3, 4'd0, 4'd5, 4'd6, 4'd0, 4'd0};
  logic [3:0] st_uop  [8] = '{4'd9, 4'd10, 4'd12, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0};
  logic [3:0] br_uop  [8] = '{4'd5, 4'd6, 4'd0, 4'd0, 4'd7, 4'd8, 4'd12, 4'd0};
  logic [4:0] opc_list [16] = '{LOAD, OPIMM, AUIPC, STORE, OP, LUI, OPV, BRANCH,
                                JALR, JAL, SYSTEM, OP, OPIMM, LOAD, STORE, BRANCH};

  core_frontend_top UUT (.*);

  bind core_frontend_top core_frontend_properties u_props (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $fatal(1);
  end

  // ============================================================
  // Checking helpers and reference model
  // ============================================================
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic expect_t predict(input logic [31:0] w);
    expect_t     e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] sx;
    f3 = w[14:12];
    f7 = w[31:25];
    sx = $signed(w) >>> 20;   // I-type immediate
    e  = '0;
    case (w[6:2])
      OP: begin
        e.uop = alu_uop[f3];
        if (f7 == 7'h20 && f3 == 3'd0) e.uop = 4'd1;
        if (f7 == 7'h20 && f3 == 3'd5) e.uop = 4'd13;
        if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) e.port = P_EXC;
      end
      OPIMM: begin
        e.uop     = (f3 == 3'd5 && f7 == 7'h20) ? 4'd13 : alu_uop[f3];
        e.imm_sel = 1'b1;
        e.imm     = sx;
        if (f3 == 3'd1 && f7 != 7'h00) e.port = P_EXC;
        if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20) e.port = P_EXC;
      end
      LOAD: begin
        e.port    = (ld_uop[f3] == 4'd0) ? P_EXC : P_LSU;
        e.uop     = ld_uop[f3];
        e.imm_sel = 1'b1;
        e.imm     = sx;
      end
      STORE: begin
        e.port    = (st_uop[f3] == 4'd0) ? P_EXC : P_LSU;
        e.uop     = st_uop[f3];
        e.imm_sel = 1'b1;
        e.imm     = {sx[31:5], w[11:7]};
      end
      BRANCH: begin
        e.port   = (f3 == 3'd2 || f3 == 3'd3) ? P_EXC : P_INT;
        e.uop    = br_uop[f3];   // BGEU lands on zero
        e.pc_sel = 1'b1;
        e.imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      LUI: begin
        e.uop     = 4'd9;
        e.imm_sel = 1'b1;
        e.imm     = {w[31:12], 12'h000};
      end
      AUIPC: begin
        e.pc_sel  = 1'b1;
        e.imm_sel = 1'b1;
        e.imm     = {w[31:12], 12'h000};
      end
      JAL: begin
        e.pc_sel  = 1'b1;
        e.imm_sel = 1'b1;
        e.imm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      JALR: begin
        e.pc_sel  = 1'b1;
        e.imm_sel = 1'b1;
        e.imm     = sx;
      end
      SYSTEM: e.imm = sx;          // Plain ADD on int unit
      OPV: begin
        e.port = P_VEC;
        e.uop  = {1'b0, f3};
      end
      default: e.port = P_EXC;
    endcase
    if (w[1:0] != 2'b11) e.port = P_EXC;
    return e;
  endfunction

  // ============================================================
  // Output monitor and scoreboard
  // ============================================================
  always @(posedge clk) begin : monitor
    expect_t    e;
    logic [1:0] seen;
    logic       fire;
    if (!arst_n) begin
      instr_q.delete();            // Held packet is dropped
      pc_q.delete();
      cyc_q.delete();
    end else begin
      if ($countones({int_valid, lsu_valid, vec_valid, exc_valid}) > 1)
        abort_run("more than one output valid is high");
      if (int_valid || lsu_valid || vec_valid || exc_valid) begin
        if (instr_q.size() == 0) begin
          abort_run("an output valid is high with no instruction pending");
        end else begin
          seen = int_valid ? P_INT : lsu_valid ? P_LSU : vec_valid ? P_VEC : P_EXC;
          fire = (int_valid && int_ready) || (lsu_valid && lsu_ready) ||
                 (vec_valid && vec_ready) || (exc_valid && exc_ready);
          e = predict(instr_q[0]);
          check("port", 32'(seen), 32'(e.port));
          if (seen == P_EXC) begin
            check("exc_instr", exc_instr, instr_q[0]);
            check("exc_pc", exc_pc, pc_q[0]);
          end else begin
            check("out_uop", 32'(out_uop), 32'(e.uop));
            check("out_imm", out_imm, e.imm);
            check("out_pc", out_pc, pc_q[0]);
            check("out_pc_sel", 32'(out_pc_sel), 32'(e.pc_sel));
            check("out_imm_sel", 32'(out_imm_sel), 32'(e.imm_sel));
            check("out_rs1", 32'(out_rs1), 32'(instr_q[0][19:15]));
            check("out_rs2", 32'(out_rs2), 32'(instr_q[0][24:20]));
            check("out_rd", 32'(out_rd), 32'(instr_q[0][11:7]));
          end
          if (fire) begin
            if (strict_latency)
              check("latency", 32'(cycle - cyc_q[0]), 32'd1);
            void'(instr_q.pop_front());
            void'(pc_q.pop_front());
            void'(cyc_q.pop_front());
          end
        end
      end
      if (in_valid && in_ready) begin
        instr_q.push_back(in_instr);
        pc_q.push_back(in_pc);
        cyc_q.push_back(cycle);
        n_accepted++;
      end
    end
    cycle++;
  end

  // ============================================================
  // Stimulus helpers, all called on the falling edge
  // ============================================================
  task automatic set_ready(input logic v);
    int_ready = v;
    lsu_ready = v;
    vec_ready = v;
    exc_ready = v;
  endtask

  task automatic next_cycle();
    logic [31:0] r;
    @(negedge clk);
    if (rand_ready) begin
      r = xorshift();
      int_ready = r[0] | r[1];     // Ready about three quarters of the time
      lsu_ready = r[2] | r[3];
      vec_ready = r[4] | r[5];
      exc_ready = r[6] | r[7];
    end
  endtask

  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] opc);
    logic [31:0] r;
    r = xorshift();                // Random rs1, rs2, rd
    return {f7, r[24:20], r[19:15], f3, r[11:7], opc, 2'b11};
  endfunction

  function automatic logic [31:0] random_legal();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  opc;
    r   = xorshift();
    opc = opc_list[r[3:0]];
    f3  = r[6:4];
    f7  = r[31:25];
    case (opc)
      LOAD:   if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
      STORE:  if (f3 > 3'd2) f3 = 3'd0;
      BRANCH: if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd7;
      OP:     f7 = (r[7] && (f3 == 3'd0 || f3 == 3'd5)) ? FUNCT7_ALT : 7'h00;
      OPIMM: begin
        if (f3 == 3'd1) f7 = 7'h00;
        if (f3 == 3'd5) f7 = r[7] ? FUNCT7_ALT : 7'h00;
      end
      default: ;
    endcase
    return encode(f7, f3, opc);
  endfunction

  // Returns on the falling edge after the input handshake, in_valid still high
  task automatic send(input logic [31:0] instr);
    int target;
    target   = n_accepted + 1;
    in_valid = 1'b1;
    in_instr = instr;
    in_pc    = pc_next;
    pc_next  = pc_next + 32'd4;
    next_cycle();
    while (n_accepted < target) next_cycle();
  endtask

  task automatic drain();
    in_valid = 1'b0;
    while (instr_q.size() != 0) next_cycle();
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic int_alu_decode();
    logic [31:0] r;
    for (int f3 = 0; f3 < 8; f3++) begin
      r = xorshift();
      send(encode(7'h00, 3'(f3), OP));
      send(encode(FUNCT7_ALT, 3'(f3), OP));
      send(encode(7'h00, 3'(f3), OPIMM));
      send(encode(FUNCT7_ALT, 3'(f3), OPIMM));
      send(encode(r[31:25], 3'(f3), OPIMM));  // Random immediate
    end
    r = xorshift();
    send(encode(r[31:25], r[14:12], LUI));
    send(encode(r[24:18], r[11:9], AUIPC));
    drain();
  endtask

  task automatic load_store_decode();
    logic [31:0] r;
    for (int f3 = 0; f3 < 8; f3++) begin
      r = xorshift();
      if (f3 != 3 && f3 < 6) send(encode(r[31:25], 3'(f3), LOAD));
      if (f3 < 3) send(encode(r[24:18], 3'(f3), STORE));
    end
    drain();
  endtask

  task automatic branch_jump_decode();
    logic [31:0] r;
    for (int f3 = 0; f3 < 8; f3++) begin
      r = xorshift();
      if (f3 != 2 && f3 != 3) send(encode(r[31:25], 3'(f3), BRANCH));
      send(encode(r[24:18], 3'(f3), OPV));
    end
    r = xorshift();
    send(encode(r[31:25], r[14:12], JAL));
    send(encode(r[24:18], 3'd0, JALR));
    send(encode(r[17:11], 3'd0, SYSTEM));
    drain();
  endtask

  task automatic illegal_routing();
    send(encode(7'h00, 3'd0, 5'b11111));           // Unknown opcode
    send(encode(7'h00, 3'd3, LOAD));               // Bad funct3
    send(encode(7'h00, 3'd2, BRANCH));
    send(encode(7'h01, 3'd0, OP));                 // Bad funct7
    send(encode(7'h00, 3'd0, OP) & ~32'h3);        // Low bits 00
    drain();
  endtask

  task automatic backpressure_stream();
    rand_ready = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) send(random_legal());
    drain();
    rand_ready = 1'b0;
    set_ready(1'b1);
  endtask

  task automatic reset_while_held();
    set_ready(1'b0);
    send(encode(7'h00, 3'd0, OP));
    in_valid = 1'b0;
    check("int_valid", 32'(int_valid), 32'd1);   // Packet stuck in the stage
    check("in_ready", 32'(in_ready), 32'd0);
    arst_n = 1'b0;
    repeat (2) next_cycle();
    arst_n = 1'b1;
    next_cycle();
    check("in_ready", 32'(in_ready), 32'd1);
    check("output valids", 32'({int_valid, lsu_valid, vec_valid, exc_valid}), 32'd0);
    set_ready(1'b1);
    send(encode(7'h00, 3'd4, OP));               // Still works afterwards
    drain();
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    arst_n         = 1'b0;
    in_valid       = 1'b0;
    in_instr       = 32'h0;
    in_pc          = 32'h0;
    strict_latency = 1'b1;
    rand_ready     = 1'b0;
    set_ready(1'b1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    int_alu_decode();
    load_store_decode();
    branch_jump_decode();
    illegal_routing();
    strict_latency = 1'b0;                        // Stalls stretch latency
    backpressure_stream();
    reset_while_held();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* flist.f */
rtl/core_pkg.sv
rtl/decode_if.sv
rtl/decode_unit.sv
rtl/imm_gen.sv
rtl/decode_stage.sv
rtl/dispatch_unit.sv
rtl/core_frontend_top.sv
dv/core_frontend_properties.sv
dv/tb_core_frontend.sv

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_core_frontend -f flist.f \
  && { ./obj_dir/Vtb_core_frontend 2>&1 | tee sim.log; } \
  && ! grep -q "Testbench failed" sim.log \
  && grep -q "Testbench passed" sim.log \
  && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }
